/* design/dbus_pkg.sv */
package dbus_pkg;

    // Bus width
    localparam int DBUS_ADDR_WIDTH = 32;

    // Data memory region, base 0x8000_0000
    localparam int DEV_SEL_ADDR_HIGH = 31;
    localparam int DEV_SEL_ADDR_LOW  = 28;
    localparam logic [DEV_SEL_ADDR_HIGH-DEV_SEL_ADDR_LOW:0] DMEM_ADDR_MATCH = 4'h8;

    // Boot memory region, base 0x0001_0000
    localparam int BMEM_SEL_ADDR_HIGH = 31;
    localparam int BMEM_SEL_ADDR_LOW  = 16;
    localparam logic [BMEM_SEL_ADDR_HIGH-BMEM_SEL_ADDR_LOW:0] BMEM_ADDR_MATCH = 16'h0001;

    // Peripheral region, timer at 0x0200_0000
    localparam int PERI_SEL_ADDR_HIGH = 31;
    localparam int PERI_SEL_ADDR_LOW  = 20;
    localparam logic [PERI_SEL_ADDR_HIGH-PERI_SEL_ADDR_LOW:0] CLINT_ADDR_MATCH = 12'h020;

    // Memory sizes in words
    localparam int DMEM_DEPTH = 1024;
    localparam int BMEM_DEPTH = 16;

    // Timer register offsets
    localparam logic [3:0] CLINT_MTIME_LO    = 4'h0;
    localparam logic [3:0] CLINT_MTIME_HI    = 4'h4;
    localparam logic [3:0] CLINT_MTIMECMP_LO = 4'h8;
    localparam logic [3:0] CLINT_MTIMECMP_HI = 4'hC;

    // Store width requested by the LSU
    typedef enum logic [1:0] {
        ST_OPS_NONE = 2'b00,
        ST_OPS_SB   = 2'b01,
        ST_OPS_SH   = 2'b10,
        ST_OPS_SW   = 2'b11
    } type_st_ops_e;

    // LSU request into the bus
    typedef struct packed {
        logic [DBUS_ADDR_WIDTH-1:0] addr;
        logic [31:0]                w_data;   // Store value in the low bits
        type_st_ops_e               st_ops;
        logic                       ld_req;
        logic                       st_req;
    } type_lsu2dbus_s;

    // Response back to the LSU
    typedef struct packed {
        logic [31:0] r_data;
        logic        ack;
    } type_dbus2lsu_s;

    // Device response, same layout as type_dbus2lsu_s
    typedef struct packed {
        logic [31:0] r_data;
        logic        ack;
    } type_peri2dbus_s;

    // Request broadcast to the devices
    typedef struct packed {
        logic [DBUS_ADDR_WIDTH-1:0] addr;
        logic [31:0]                w_data;   // Already on its byte lanes
        logic [3:0]                 sel_byte;
        logic                       w_en;
        logic                       req;
    } type_dbus2peri_s;

endpackage : dbus_pkg

/* design/dbus_interconnect.sv */
module dbus_interconnect (
    input  logic                     clk,
    input  logic                     rst_i,

    // Load/store unit side
    input  dbus_pkg::type_lsu2dbus_s lsu2dbus_i,
    output dbus_pkg::type_dbus2lsu_s dbus2lsu_o,

    // Device responses
    input  dbus_pkg::type_peri2dbus_s dmem2dbus_i,
    input  dbus_pkg::type_peri2dbus_s bmem2dbus_i,
    input  dbus_pkg::type_peri2dbus_s clint2dbus_i,

    // Device selects
    output logic                     dmem_sel_o,
    output logic                     bmem_sel_o,
    output logic                     clint_sel_o,

    // Shared request to all devices
    output dbus_pkg::type_dbus2peri_s dbus2peri_o
);

    import dbus_pkg::*;

    logic [DBUS_ADDR_WIDTH-1:0] dbus_addr;
    logic                       dbus_req;

    logic                       dmem_addr_match;
    logic                       bmem_addr_match;
    logic                       clint_addr_match;

    logic                       dmem_sel;
    logic                       bmem_sel;
    logic                       clint_sel;

    logic [31:0]                lane_data;
    logic [3:0]                 lane_sel;

    assign dbus_addr = lsu2dbus_i.addr;
    assign dbus_req  = lsu2dbus_i.ld_req | lsu2dbus_i.st_req;

    // Region matches
    assign dmem_addr_match  = (dbus_addr[DEV_SEL_ADDR_HIGH:DEV_SEL_ADDR_LOW] == DMEM_ADDR_MATCH);
    assign bmem_addr_match  = (dbus_addr[BMEM_SEL_ADDR_HIGH:BMEM_SEL_ADDR_LOW] == BMEM_ADDR_MATCH);
    assign clint_addr_match = (dbus_addr[PERI_SEL_ADDR_HIGH:PERI_SEL_ADDR_LOW] == CLINT_ADDR_MATCH);

    // Store lane steering
    always_comb begin
        lane_data = '0;
        lane_sel  = 4'b0000;

        case (lsu2dbus_i.st_ops)
            ST_OPS_SB: begin
                case (dbus_addr[1:0])
                    2'b00: begin
                        lane_data[7:0] = lsu2dbus_i.w_data[7:0];
                        lane_sel       = 4'b0001;
                    end
                    2'b01: begin
                        lane_data[15:8] = lsu2dbus_i.w_data[7:0];
                        lane_sel        = 4'b0010;
                    end
                    2'b10: begin
                        lane_data[23:16] = lsu2dbus_i.w_data[7:0];
                        lane_sel         = 4'b0100;
                    end
                    default: begin
                        lane_data[31:24] = lsu2dbus_i.w_data[7:0];
                        lane_sel         = 4'b1000;
                    end
                endcase
            end
            ST_OPS_SH: begin
                if (dbus_addr[1]) begin
                    lane_data[31:16] = lsu2dbus_i.w_data[15:0];  // Upper half
                    lane_sel         = 4'b1100;
                end else begin
                    lane_data[15:0] = lsu2dbus_i.w_data[15:0];
                    lane_sel        = 4'b0011;
                end
            end
            ST_OPS_SW: begin
                lane_data = lsu2dbus_i.w_data;
                lane_sel  = 4'b1111;
            end
            default: begin
                lane_data = '0;  // No store
                lane_sel  = 4'b0000;
            end
        endcase
    end

    // Fixed priority device select
    always_comb begin
        dmem_sel  = 1'b0;
        clint_sel = 1'b0;
        bmem_sel  = 1'b0;

        if (dmem_addr_match & dbus_req) begin
            dmem_sel = 1'b1;
        end else if (clint_addr_match & dbus_req) begin
            clint_sel = 1'b1;
        end else if (bmem_addr_match & dbus_req) begin
            bmem_sel = 1'b1;
        end
    end

    assign dbus2peri_o.addr     = dbus_addr;
    assign dbus2peri_o.w_data   = lane_data;
    assign dbus2peri_o.sel_byte = lane_sel;
    assign dbus2peri_o.w_en     = lsu2dbus_i.st_req;
    assign dbus2peri_o.req      = dbus_req;

    assign dmem_sel_o  = dmem_sel;
    assign bmem_sel_o  = bmem_sel;
    assign clint_sel_o = clint_sel;

    // Unmapped requests get an all-zero response and never see ack
    assign dbus2lsu_o = dmem_sel  ? type_dbus2lsu_s'(dmem2dbus_i)
                      : clint_sel ? type_dbus2lsu_s'(clint2dbus_i)
                      : bmem_sel  ? type_dbus2lsu_s'(bmem2dbus_i)
                      : '0;

endmodule : dbus_interconnect

/* design/data_mem.sv */
module data_mem (
    input  logic                      clk,
    input  logic                      rst_i,
    input  dbus_pkg::type_dbus2peri_s dbus2peri_i,
    input  logic                      sel_i,
    output dbus_pkg::type_peri2dbus_s dmem2dbus_o
);

    import dbus_pkg::*;

    logic [31:0]                   mem [DMEM_DEPTH];
    logic [$clog2(DMEM_DEPTH)-1:0] word_idx;
    logic                          access;
    logic [31:0]                   r_data;
    logic                          ack;

    assign word_idx = dbus2peri_i.addr[$clog2(DMEM_DEPTH)+1:2];

    // New request only, never back to back with our own ack
    assign access = sel_i & dbus2peri_i.req & ~ack;

    // Byte-lane writes
    always_ff @(posedge clk) begin
        if (access & dbus2peri_i.w_en) begin
            for (int b = 0; b < 4; b++) begin
                if (dbus2peri_i.sel_byte[b]) begin
                    mem[word_idx][8*b +: 8] <= dbus2peri_i.w_data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            r_data <= mem[word_idx];  // Full aligned word
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    assign dmem2dbus_o.r_data = r_data;
    assign dmem2dbus_o.ack    = ack;

endmodule : data_mem

/* design/boot_rom.sv */
module boot_rom (
    input  logic                      clk,
    input  logic                      rst_i,
    input  dbus_pkg::type_dbus2peri_s dbus2peri_i,
    input  logic                      sel_i,
    output dbus_pkg::type_peri2dbus_s bmem2dbus_o
);

    import dbus_pkg::*;

    logic [31:0] rom [BMEM_DEPTH];
    logic        access;
    logic [31:0] r_data;
    logic        ack;

    initial begin
        $readmemh("boot_rom.hex", rom);
    end

    // Writes are acknowledged like reads and dropped
    assign access = sel_i & dbus2peri_i.req & ~ack;

    always_ff @(posedge clk) begin
        if (access) begin
            r_data <= rom[dbus2peri_i.addr[$clog2(BMEM_DEPTH)+1:2]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    assign bmem2dbus_o.r_data = r_data;
    assign bmem2dbus_o.ack    = ack;

endmodule : boot_rom

/* design/clint_timer.sv */
module clint_timer (
    input  logic                      clk,
    input  logic                      rst_i,
    input  dbus_pkg::type_dbus2peri_s dbus2peri_i,
    input  logic                      sel_i,
    output dbus_pkg::type_peri2dbus_s clint2dbus_o,
    output logic                      timer_irq_o
);

    import dbus_pkg::*;

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [3:0]  reg_off;
    logic        access;
    logic        wr_en;
    logic [31:0] r_data;
    logic        ack;

    // Replace only the enabled bytes of a 32-bit half
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  sel);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    assign reg_off = {dbus2peri_i.addr[3:2], 2'b00};
    assign access  = sel_i & dbus2peri_i.req & ~ack;
    assign wr_en   = access & dbus2peri_i.w_en;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtime    <= '0;
            mtimecmp <= '1;  // Keeps the interrupt quiet out of reset
        end else begin
            // Software write wins over the tick
            if (wr_en && reg_off == CLINT_MTIME_LO) begin
                mtime[31:0] <= merge_bytes(mtime[31:0], dbus2peri_i.w_data, dbus2peri_i.sel_byte);
            end else if (wr_en && reg_off == CLINT_MTIME_HI) begin
                mtime[63:32] <= merge_bytes(mtime[63:32], dbus2peri_i.w_data,
                                            dbus2peri_i.sel_byte);
            end else begin
                mtime <= mtime + 64'd1;
            end

            if (wr_en && reg_off == CLINT_MTIMECMP_LO) begin
                mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], dbus2peri_i.w_data,
                                              dbus2peri_i.sel_byte);
            end else if (wr_en && reg_off == CLINT_MTIMECMP_HI) begin
                mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], dbus2peri_i.w_data,
                                               dbus2peri_i.sel_byte);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (reg_off)
                CLINT_MTIME_LO:    r_data <= mtime[31:0];
                CLINT_MTIME_HI:    r_data <= mtime[63:32];
                CLINT_MTIMECMP_LO: r_data <= mtimecmp[31:0];
                CLINT_MTIMECMP_HI: r_data <= mtimecmp[63:32];
                default:           r_data <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack         <= 1'b0;
            timer_irq_o <= 1'b0;
        end else begin
            ack         <= access;
            timer_irq_o <= (mtime >= mtimecmp);  // One cycle behind the compare
        end
    end

    assign clint2dbus_o.r_data = r_data;
    assign clint2dbus_o.ack    = ack;

endmodule : clint_timer

/* design/dbus_subsys_top.sv */
module dbus_subsys_top (
    input  logic                     clk,
    input  logic                     rst_i,
    input  dbus_pkg::type_lsu2dbus_s lsu2dbus_i,
    output dbus_pkg::type_dbus2lsu_s dbus2lsu_o,
    output logic                     timer_irq_o
);

    import dbus_pkg::*;

    type_dbus2peri_s dbus2peri;   // Broadcast to every device
    type_peri2dbus_s dmem2dbus;
    type_peri2dbus_s bmem2dbus;
    type_peri2dbus_s clint2dbus;

    logic            dmem_sel;
    logic            bmem_sel;
    logic            clint_sel;

    dbus_interconnect dbus_interconnect_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .lsu2dbus_i   (lsu2dbus_i),
        .dmem2dbus_i  (dmem2dbus),
        .bmem2dbus_i  (bmem2dbus),
        .clint2dbus_i (clint2dbus),
        .dbus2lsu_o   (dbus2lsu_o),
        .dmem_sel_o   (dmem_sel),
        .bmem_sel_o   (bmem_sel),
        .clint_sel_o  (clint_sel),
        .dbus2peri_o  (dbus2peri)
    );

    data_mem data_mem_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .dbus2peri_i (dbus2peri),
        .sel_i       (dmem_sel),
        .dmem2dbus_o (dmem2dbus)
    );

    boot_rom boot_rom_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .dbus2peri_i (dbus2peri),
        .sel_i       (bmem_sel),
        .bmem2dbus_o (bmem2dbus)
    );

    clint_timer clint_timer_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .dbus2peri_i  (dbus2peri),
        .sel_i        (clint_sel),
        .clint2dbus_o (clint2dbus),
        .timer_irq_o  (timer_irq_o)
    );

endmodule : dbus_subsys_top

/* verification/dbus_subsys_tests.svh */
`ifndef DBUS_SUBSYS_TESTS_SVH
`define DBUS_SUBSYS_TESTS_SVH

logic [31:0] rt_addrs [20];  // Word addresses used by the round trip

task automatic test_word_round_trip();
    for (int i = 0; i < 20; i++) begin
        rt_addrs[i] = 32'h8000_0000 | (lcg_next() & 32'h0000_0FFC);
        dmem_store(rt_addrs[i], lcg_next(), ST_OPS_SW);
    end
    for (int i = 0; i < 20; i++) begin
        load_check("dbus2lsu_o dmem word", rt_addrs[i], dmem_model[rt_addrs[i][11:2]]);
    end
endtask

task automatic test_byte_half_lanes();
    logic [31:0] lane_addr;
    lane_addr = 32'h8000_0200;
    for (int off = 0; off < 4; off++) begin
        dmem_store(lane_addr, 32'hA5C3_5A3C, ST_OPS_SW);
        // Upper bits set so a wrong lane shows up
        dmem_store(lane_addr + off, 32'hFFFF_FF00 | (8'h11 * (off + 1)), ST_OPS_SB);
        load_check("dbus2lsu_o byte lane", lane_addr, dmem_model[lane_addr[11:2]]);
    end
    for (int off = 0; off < 4; off += 2) begin
        dmem_store(lane_addr, 32'hA5C3_5A3C, ST_OPS_SW);
        dmem_store(lane_addr + off, 32'hDEAD_0000 | (16'h1234 + off), ST_OPS_SH);
        load_check("dbus2lsu_o halfword lane", lane_addr, dmem_model[lane_addr[11:2]]);
    end
endtask

task automatic test_boot_rom();
    for (int i = 0; i < BMEM_DEPTH; i++) begin
        load_check("dbus2lsu_o boot word", 32'h0001_0000 + 4 * i, boot_model[i]);
    end
    store_op(32'h0001_0014, 32'hDEAD_BEEF, ST_OPS_SW);  // Dropped by the ROM
    load_check("dbus2lsu_o boot after store", 32'h0001_0014, boot_model[5]);
endtask

task automatic test_timer();
    type_dbus2lsu_s resp;
    logic [31:0]    first;
    logic [31:0]    second;
    int             wait_cycles;
    load_raw(32'h0200_0000, resp);
    first = resp.r_data;
    load_raw(32'h0200_0000, resp);
    second = resp.r_data;
    if (!(second > first)) begin
        $display("mtime did not advance between reads: first %0d, second %0d", first, second);
        err_count++;
    end
    store_op(32'h0200_000C, 32'h0000_0000, ST_OPS_SW);
    store_op(32'h0200_0008, second + 32'd50, ST_OPS_SW);
    check_irq("timer_irq_o", timer_irq, 1'b0);
    wait_cycles = 0;
    while (timer_irq !== 1'b1 && wait_cycles < 100) begin
        @(negedge clk);
        wait_cycles++;
    end
    if (timer_irq !== 1'b1) begin
        $display("timer_irq_o did not rise within 100 cycles of setting mtimecmp");
        err_count++;
    end
    // High half alone already puts mtimecmp above mtime
    store_op(32'h0200_000C, 32'hFFFF_FFFF, ST_OPS_SW);
    wait_cycles = 0;
    while (timer_irq !== 1'b0 && wait_cycles < 3) begin
        @(negedge clk);
        wait_cycles++;
    end
    if (timer_irq !== 1'b0) begin
        $display("timer_irq_o did not fall within 3 cycles of restoring mtimecmp");
        err_count++;
    end
    store_op(32'h0200_0008, 32'hFFFF_FFFF, ST_OPS_SW);
    check_irq("timer_irq_o", timer_irq, 1'b0);
endtask

task automatic test_unmapped();
    type_lsu2dbus_s req;
    type_dbus2lsu_s idle;
    req        = '0;
    req.addr   = 32'h4000_0000;
    req.ld_req = 1'b1;
    idle       = '0;  // No device selected, so all zeros
    @(negedge clk);
    lsu2dbus = req;
    for (int i = 0; i < 8; i++) begin
        @(negedge clk);
        check_resp("dbus2lsu_o unmapped", dbus2lsu, idle);
    end
    lsu2dbus = '0;
    load_check("dbus2lsu_o dmem after unmapped", rt_addrs[0], dmem_model[rt_addrs[0][11:2]]);
endtask

`endif

/* verification/dbus_subsys_tb.sv */
module dbus_subsys_tb;

    import dbus_pkg::*;

    logic           clk;
    logic           rst;
    type_lsu2dbus_s lsu2dbus;
    type_dbus2lsu_s dbus2lsu;
    logic           timer_irq;

    logic [31:0]    dmem_model [DMEM_DEPTH];  // Expected data memory contents
    logic [31:0]    boot_model [BMEM_DEPTH];
    logic [31:0]    lcg_state;
    int             err_count;
    int             tests_passed;
    int             tests_failed;

    dbus_subsys_top dbus_subsys_top_i (
        .clk         (clk),
        .rst_i       (rst),
        .lsu2dbus_i  (lsu2dbus),
        .dbus2lsu_o  (dbus2lsu),
        .timer_irq_o (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_resp(input string name, input type_dbus2lsu_s got,
                              input type_dbus2lsu_s exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s got r_data=%08h ack=%b, expected r_data=%08h ack=%b",
                     $time, name, got.r_data, got.ack, exp.r_data, exp.ack);
            err_count++;
        end
    endtask

    task automatic check_irq(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s got %b, expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    // Holds the request until ack, then releases it on the same falling edge
    task automatic bus_access(input type_lsu2dbus_s req, output type_dbus2lsu_s resp);
        int cycles;
        cycles = 0;
        @(negedge clk);
        lsu2dbus = req;
        do begin
            @(negedge clk);
            cycles++;
        end while (dbus2lsu.ack !== 1'b1 && cycles < 10);
        resp     = dbus2lsu;
        lsu2dbus = '0;
        if (resp.ack !== 1'b1) begin
            $display("Access to address %08h was not acknowledged within 10 cycles", req.addr);
            err_count++;
        end else if (cycles != 1) begin
            $display("Access to address %08h was acknowledged after %0d cycles instead of 1",
                     req.addr, cycles);
            err_count++;
        end
    endtask

    task automatic store_op(input logic [31:0] addr, input logic [31:0] data,
                            input type_st_ops_e ops);
        type_lsu2dbus_s req;
        type_dbus2lsu_s resp;
        req        = '0;
        req.addr   = addr;
        req.w_data = data;
        req.st_ops = ops;
        req.st_req = 1'b1;
        bus_access(req, resp);
    endtask

    task automatic load_raw(input logic [31:0] addr, output type_dbus2lsu_s resp);
        type_lsu2dbus_s req;
        req        = '0;
        req.addr   = addr;
        req.ld_req = 1'b1;
        bus_access(req, resp);
    endtask

    task automatic load_check(input string name, input logic [31:0] addr,
                              input logic [31:0] exp_data);
        type_dbus2lsu_s resp;
        type_dbus2lsu_s exp;
        exp.r_data = exp_data;
        exp.ack    = 1'b1;
        load_raw(addr, resp);
        check_resp(name, resp, exp);
    endtask

    // Store to data memory and apply the lane rule to the model
    task automatic dmem_store(input logic [31:0] addr, input logic [31:0] data,
                              input type_st_ops_e ops);
        int idx;
        idx = addr[11:2];
        store_op(addr, data, ops);
        case (ops)
            ST_OPS_SB: dmem_model[idx][8*addr[1:0] +: 8] = data[7:0];
            ST_OPS_SH: dmem_model[idx][16*addr[1] +: 16] = data[15:0];
            ST_OPS_SW: dmem_model[idx] = data;
            default:   ;  // No lanes written
        endcase
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("Test %s: PASS", name);
            tests_passed++;
        end else begin
            $display("Test %s: FAIL with %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    `include "dbus_subsys_tests.svh"

    initial begin
        int errs;
        lsu2dbus     = '0;
        rst          = 1'b1;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        lcg_state    = 32'd6;
        $readmemh("boot_rom.hex", boot_model);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errs = err_count;
        test_word_round_trip();
        finish_test("word round trip", errs);
        errs = err_count;
        test_byte_half_lanes();
        finish_test("byte and halfword lanes", errs);
        errs = err_count;
        test_boot_rom();
        finish_test("boot memory", errs);
        errs = err_count;
        test_timer();
        finish_test("timer", errs);
        errs = err_count;
        test_unmapped();
        finish_test("unmapped address", errs);

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : dbus_subsys_tb

/* boot_rom.hex */
// One 32-bit boot word per line in hex, word 0 first
00000297
02028293
30529073
00001137
80010113
0040006f
fe010113
00112e23
00812c23
02010413
800007b7
00078793
0007a703
00170713
00e7a023
ff1ff06f

/* dbus_subsys.f */
+incdir+verification
design/dbus_pkg.sv
design/dbus_interconnect.sv
design/data_mem.sv
design/boot_rom.sv
design/clint_timer.sv
design/dbus_subsys_top.sv
verification/dbus_subsys_tb.sv
